// ==== Bender.yml ====
package:
  name: beta_urom

sources:
  - files:
      - hdl/beta_urom_pkg.sv
      - hdl/urom_mem_dec.sv
      - hdl/urom_alu_dec.sv
      - hdl/urom_flow_dec.sv
      - hdl/beta_urom.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_beta_urom.sv

// ==== beta_urom.f ====
hdl/beta_urom_pkg.sv
hdl/urom_mem_dec.sv
hdl/urom_alu_dec.sv
hdl/urom_flow_dec.sv
hdl/beta_urom.sv
test/tb_clk_gen.sv
test/tb_beta_urom.sv

// ==== hdl/beta_urom.sv ====
module beta_urom import beta_urom_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  urom_addr_t        urom_address_i,
	input  logic              urom_invalid_instr_i,
	output dec_control_word_t urom_control_word_o
);

	dec_control_word_t mem_cw;
	dec_control_word_t alu_cw;
	dec_control_word_t flow_cw;
	dec_control_word_t cw_next;

	urom_mem_dec u_mem (
		.urom_address_i (urom_address_i),
		.mem_cw_o       (mem_cw)
	);

	urom_alu_dec u_alu (
		.urom_address_i (urom_address_i),
		.alu_cw_o       (alu_cw)
	);

	urom_flow_dec u_flow (
		.urom_address_i (urom_address_i),
		.flow_cw_o      (flow_cw)
	);

	// Groups never overlap, so the OR picks the one that matched
	always_comb begin : cw_merge
		cw_next = mem_cw | alu_cw | flow_cw;
		if (urom_invalid_instr_i) begin
			cw_next = '0;		// Behaves as a bubble
		end
	end

	always_ff @(posedge clk_i) begin : cw_reg
		if (!rst_n_i) begin
			urom_control_word_o <= '0;
		end else begin
			urom_control_word_o <= cw_next;
		end
	end

endmodule

// ==== hdl/beta_urom_pkg.sv ====
package beta_urom_pkg;

	// Major opcode, instruction bits [6:2]
	typedef enum logic [4:0] {
		MAJOR_LOAD   = 5'h00,
		MAJOR_IMM    = 5'h04,
		MAJOR_AUIPC  = 5'h05,
		MAJOR_STORE  = 5'h08,
		MAJOR_REG    = 5'h0C,
		MAJOR_LUI    = 5'h0D,
		MAJOR_BRANCH = 5'h18,
		MAJOR_JALR   = 5'h19,
		MAJOR_JAL    = 5'h1B
	} urom_major_e;

	// Micro-address as built by the instruction decoder
	typedef struct packed {
		urom_major_e major;		// Opcode bits [6:2]
		logic [2:0]  minor;		// funct3
		logic        alt;		// funct7 bit 5
	} urom_addr_t;

	// Load minor codes
	localparam logic [2:0] MINOR_LB   = 3'b000;
	localparam logic [2:0] MINOR_LH   = 3'b001;
	localparam logic [2:0] MINOR_LW   = 3'b010;
	localparam logic [2:0] MINOR_LBU  = 3'b100;
	localparam logic [2:0] MINOR_LHU  = 3'b101;

	// Store minor codes
	localparam logic [2:0] MINOR_SB   = 3'b000;
	localparam logic [2:0] MINOR_SH   = 3'b001;
	localparam logic [2:0] MINOR_SW   = 3'b010;

	// ALU minor codes, shared by immediate and register forms
	localparam logic [2:0] MINOR_ADD  = 3'b000;		// SUB with alt
	localparam logic [2:0] MINOR_SLL  = 3'b001;
	localparam logic [2:0] MINOR_SLT  = 3'b010;
	localparam logic [2:0] MINOR_SLTU = 3'b011;
	localparam logic [2:0] MINOR_XOR  = 3'b100;
	localparam logic [2:0] MINOR_SRL  = 3'b101;		// SRA with alt
	localparam logic [2:0] MINOR_OR   = 3'b110;
	localparam logic [2:0] MINOR_AND  = 3'b111;

	// Branch minor codes
	localparam logic [2:0] MINOR_BEQ  = 3'b000;
	localparam logic [2:0] MINOR_BNE  = 3'b001;
	localparam logic [2:0] MINOR_BLT  = 3'b100;
	localparam logic [2:0] MINOR_BGE  = 3'b101;
	localparam logic [2:0] MINOR_BLTU = 3'b110;
	localparam logic [2:0] MINOR_BGEU = 3'b111;

	typedef enum logic [1:0] {
		MEM_SIZE_BYTE = 2'd0,
		MEM_SIZE_HALF = 2'd1,
		MEM_SIZE_WORD = 2'd2
	} mem_size_e;

	typedef enum logic {
		MEM_LOAD_OP  = 1'b0,
		MEM_STORE_OP = 1'b1
	} mem_op_e;

	// Source register usage, read by the hazard logic
	localparam logic [1:0] SRC_USED_RS1     = 2'd0;
	localparam logic [1:0] SRC_USED_RS1_RS2 = 2'd1;
	localparam logic [1:0] SRC_USED_NONE    = 2'd2;

	// Operand 1 mux
	localparam logic [1:0] SRC1_REG   = 2'd0;
	localparam logic [1:0] SRC1_UPPER = 2'd1;

	// Operand 2 mux
	localparam logic [1:0] SRC2_REG   = 2'd0;
	localparam logic [1:0] SRC2_IMM12 = 2'd1;
	localparam logic [1:0] SRC2_IMM20 = 2'd2;
	localparam logic [1:0] SRC2_UPPER = 2'd3;

	// Logic unit operation, zero means idle
	localparam logic [1:0] LOGIC_AND = 2'd1;
	localparam logic [1:0] LOGIC_OR  = 2'd2;
	localparam logic [1:0] LOGIC_XOR = 2'd3;

	// Shift unit operation, zero means idle
	localparam logic [1:0] SHIFT_LL = 2'd1;
	localparam logic [1:0] SHIFT_RL = 2'd2;
	localparam logic [1:0] SHIFT_RA = 2'd3;

	// ALU flag that feeds the condition
	localparam logic [1:0] COND_NEG_BIT  = 2'd1;
	localparam logic [1:0] COND_ZERO_BIT = 2'd2;

	// Branch and jump unit mode
	localparam logic [1:0] BJU_BRANCH   = 2'd1;
	localparam logic [1:0] BJU_JUMP     = 2'd2;
	localparam logic [1:0] BJU_JUMP_REG = 2'd3;

	// Control word carried from decode into execute
	typedef struct packed {
		logic [1:0] src_reg_used;
		logic [1:0] dec_src1_select;
		logic [1:0] dec_src2_select;
		logic       dec_not_sign_ext;		// Zero-extend immediate or load data
		logic       exe_alu_add_en;
		logic       exe_alu_sub_en;
		logic [1:0] exe_alu_logic_en;
		logic [1:0] exe_shu_shift_en;
		logic       exe_slt_en;
		logic [1:0] exe_condition_sel;
		logic       exe_condition_neg;
		logic       exe_alu_unsigned_n_en;		// High for unsigned compare
		logic       exe_add_pc_to_res_en;
		logic [1:0] exe_bju_en;
		logic       exe_reg_wr_en;
		logic       exe_mem_op_en;
		mem_op_e    exe_mem_op;
		mem_size_e  exe_mem_op_size;
	} dec_control_word_t;

endpackage

// ==== hdl/urom_alu_dec.sv ====
module urom_alu_dec import beta_urom_pkg::*; (
	input  urom_addr_t        urom_address_i,
	output dec_control_word_t alu_cw_o
);

	logic              is_imm;
	logic              is_reg;
	logic              upper_hit;
	logic              op_hit;
	dec_control_word_t op_cw;		// Operation fields only

	assign is_imm = (urom_address_i.major == MAJOR_IMM);
	assign is_reg = (urom_address_i.major == MAJOR_REG);

	// LUI and AUIPC carry no funct3, the decoder presents zero there
	assign upper_hit = ((urom_address_i.major == MAJOR_LUI) ||
		(urom_address_i.major == MAJOR_AUIPC)) &&
		(urom_address_i.minor == 3'b000) && !urom_address_i.alt;

	always_comb begin : op_decode
		op_cw = '0;
		op_hit = 1'b1;
		case ({urom_address_i.minor, urom_address_i.alt})
			{MINOR_ADD, 1'b0}: begin
				op_cw.exe_alu_add_en = 1'b1;
			end
			{MINOR_ADD, 1'b1}: begin		// SUB, register form only
				op_cw.exe_alu_sub_en = 1'b1;
				op_hit = is_reg;
			end
			{MINOR_SLL, 1'b0}: begin
				op_cw.exe_shu_shift_en = SHIFT_LL;
			end
			{MINOR_SLT, 1'b0}: begin
				op_cw.exe_slt_en = 1'b1;
				op_cw.exe_condition_sel = COND_NEG_BIT;		// Sign of rs1 - op2
				op_cw.exe_alu_unsigned_n_en = 1'b0;
			end
			{MINOR_SLTU, 1'b0}: begin
				op_cw.exe_slt_en = 1'b1;
				op_cw.exe_condition_sel = COND_NEG_BIT;
				op_cw.exe_alu_unsigned_n_en = 1'b1;
				op_cw.dec_not_sign_ext = 1'b1;
			end
			{MINOR_XOR, 1'b0}: begin
				op_cw.exe_alu_logic_en = LOGIC_XOR;
			end
			{MINOR_SRL, 1'b0}: begin
				op_cw.exe_shu_shift_en = SHIFT_RL;
			end
			{MINOR_SRL, 1'b1}: begin		// SRA and SRAI
				op_cw.exe_shu_shift_en = SHIFT_RA;
			end
			{MINOR_OR, 1'b0}: begin
				op_cw.exe_alu_logic_en = LOGIC_OR;
			end
			{MINOR_AND, 1'b0}: begin
				op_cw.exe_alu_logic_en = LOGIC_AND;
			end
			default: begin
				op_hit = 1'b0;
			end
		endcase
	end

	always_comb begin : alu_merge
		alu_cw_o = '0;
		if ((is_imm || is_reg) && op_hit) begin
			alu_cw_o = op_cw;
			alu_cw_o.src_reg_used = is_imm ? SRC_USED_RS1 : SRC_USED_RS1_RS2;
			alu_cw_o.dec_src1_select = SRC1_REG;
			alu_cw_o.dec_src2_select = is_imm ? SRC2_IMM12 : SRC2_REG;
			alu_cw_o.exe_reg_wr_en = 1'b1;
		end else if (upper_hit) begin
			alu_cw_o.src_reg_used = SRC_USED_RS1;
			alu_cw_o.dec_src1_select = SRC1_UPPER;
			alu_cw_o.dec_src2_select = SRC2_UPPER;
			// AUIPC adds the current pc to the upper immediate
			alu_cw_o.exe_add_pc_to_res_en = (urom_address_i.major == MAJOR_AUIPC);
			alu_cw_o.exe_reg_wr_en = 1'b1;
		end
	end

endmodule

// ==== hdl/urom_flow_dec.sv ====
module urom_flow_dec import beta_urom_pkg::*; (
	input  urom_addr_t        urom_address_i,
	output dec_control_word_t flow_cw_o
);

	logic       br_hit;
	logic [1:0] br_cond;
	logic       br_neg;
	logic       br_uns;
	logic       jump_slot;

	// Jumps have no funct3 or alt of their own
	assign jump_slot = (urom_address_i.minor == 3'b000) && !urom_address_i.alt;

	always_comb begin : branch_cond
		br_hit = 1'b1;
		br_cond = COND_NEG_BIT;		// Sign of rs1 - rs2
		br_neg = 1'b0;
		br_uns = 1'b0;
		case (urom_address_i.minor)
			MINOR_BEQ: begin
				br_cond = COND_ZERO_BIT;
			end
			MINOR_BNE: begin
				br_cond = COND_ZERO_BIT;
				br_neg = 1'b1;
			end
			MINOR_BLT: begin
				br_neg = 1'b0;
			end
			MINOR_BGE: begin
				br_neg = 1'b1;		// Not less than
			end
			MINOR_BLTU: begin
				br_uns = 1'b1;
			end
			MINOR_BGEU: begin
				br_neg = 1'b1;
				br_uns = 1'b1;
			end
			default: begin
				br_hit = 1'b0;
			end
		endcase
	end

	always_comb begin : flow_decode
		flow_cw_o = '0;
		case (urom_address_i.major)
			MAJOR_BRANCH: begin
				if (br_hit && !urom_address_i.alt) begin
					flow_cw_o.src_reg_used = SRC_USED_RS1_RS2;
					flow_cw_o.dec_src1_select = SRC1_REG;
					flow_cw_o.dec_src2_select = SRC2_REG;
					flow_cw_o.exe_bju_en = BJU_BRANCH;
					flow_cw_o.exe_condition_sel = br_cond;
					flow_cw_o.exe_condition_neg = br_neg;
					flow_cw_o.exe_alu_unsigned_n_en = br_uns;
				end
			end
			MAJOR_JALR: begin
				if (jump_slot) begin
					flow_cw_o.src_reg_used = SRC_USED_RS1_RS2;
					flow_cw_o.dec_src1_select = SRC1_REG;
					flow_cw_o.dec_src2_select = SRC2_IMM12;		// Target is rs1 + imm12
					flow_cw_o.exe_bju_en = BJU_JUMP_REG;
					flow_cw_o.exe_reg_wr_en = 1'b1;		// Link address to rd
				end
			end
			MAJOR_JAL: begin
				if (jump_slot) begin
					flow_cw_o.src_reg_used = SRC_USED_NONE;
					flow_cw_o.dec_src1_select = SRC1_REG;
					flow_cw_o.dec_src2_select = SRC2_IMM20;
					flow_cw_o.exe_bju_en = BJU_JUMP;
					flow_cw_o.exe_reg_wr_en = 1'b1;
				end
			end
			default: flow_cw_o = '0;
		endcase
	end

endmodule

// ==== hdl/urom_mem_dec.sv ====
module urom_mem_dec import beta_urom_pkg::*; (
	input  urom_addr_t        urom_address_i,
	output dec_control_word_t mem_cw_o
);

	// Address is rs1 + imm12, data goes to rd
	function automatic dec_control_word_t load_cw(mem_size_e size, logic zero_ext);
		dec_control_word_t cw;
		cw = '0;
		cw.src_reg_used = SRC_USED_RS1;
		cw.dec_src1_select = SRC1_REG;
		cw.dec_src2_select = SRC2_IMM12;
		cw.dec_not_sign_ext = zero_ext;
		cw.exe_alu_add_en = 1'b1;
		cw.exe_reg_wr_en = 1'b1;
		cw.exe_mem_op_en = 1'b1;
		cw.exe_mem_op = MEM_LOAD_OP;
		cw.exe_mem_op_size = size;
		return cw;
	endfunction

	// rs2 carries the store data, no write back
	function automatic dec_control_word_t store_cw(mem_size_e size);
		dec_control_word_t cw;
		cw = '0;
		cw.src_reg_used = SRC_USED_RS1_RS2;
		cw.dec_src1_select = SRC1_REG;
		cw.dec_src2_select = SRC2_REG;
		cw.exe_mem_op_en = 1'b1;
		cw.exe_mem_op = MEM_STORE_OP;
		cw.exe_mem_op_size = size;
		return cw;
	endfunction

	always_comb begin : mem_decode
		mem_cw_o = '0;
		if (!urom_address_i.alt) begin		// No load or store uses the alt bit
			case (urom_address_i.major)
				MAJOR_LOAD: begin
					case (urom_address_i.minor)
						MINOR_LB:  mem_cw_o = load_cw(MEM_SIZE_BYTE, 1'b0);
						MINOR_LH:  mem_cw_o = load_cw(MEM_SIZE_HALF, 1'b0);
						MINOR_LW:  mem_cw_o = load_cw(MEM_SIZE_WORD, 1'b0);
						MINOR_LBU: mem_cw_o = load_cw(MEM_SIZE_BYTE, 1'b1);
						MINOR_LHU: mem_cw_o = load_cw(MEM_SIZE_HALF, 1'b1);
						default:   mem_cw_o = '0;
					endcase
				end
				MAJOR_STORE: begin
					case (urom_address_i.minor)
						MINOR_SB: mem_cw_o = store_cw(MEM_SIZE_BYTE);
						MINOR_SH: mem_cw_o = store_cw(MEM_SIZE_HALF);
						MINOR_SW: mem_cw_o = store_cw(MEM_SIZE_WORD);
						default:  mem_cw_o = '0;
					endcase
				end
				default: mem_cw_o = '0;
			endcase
		end
	end

endmodule

// ==== test/tb_beta_urom.sv ====
module tb_beta_urom import beta_urom_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 200;
	localparam int DRIVE_DELAY = 1;
	localparam int CW_BITS = $bits(dec_control_word_t);

	typedef struct packed {
		urom_addr_t        addr;
		logic              invalid;
		dec_control_word_t exp;
	} stim_entry_t;

	logic              clk;
	logic              rst_n;
	urom_addr_t        urom_address_i;
	logic              urom_invalid_instr_i;
	dec_control_word_t urom_control_word_o;

	stim_entry_t       table_q[$];
	integer            seed;
	int                errors = 0;
	int                checks = 0;
	int                cycle_count = 0;
	int                cycle_limit = 0;		// Zero until the table is built
	logic              pend_valid;
	dec_control_word_t pend_exp;
	string             pend_label;

	tb_clk_gen u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	beta_urom dut0 (
		.clk_i                (clk),
		.rst_n_i              (rst_n),
		.urom_address_i       (urom_address_i),
		.urom_invalid_instr_i (urom_invalid_instr_i),
		.urom_control_word_o  (urom_control_word_o)
	);

	task automatic check_value(string name, logic [CW_BITS-1:0] expected,
		logic [CW_BITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	function automatic dec_control_word_t mem_word(logic store, mem_size_e size, logic zext);
		dec_control_word_t w;
		w = '0;
		w.dec_src1_select = SRC1_REG;
		w.exe_mem_op_en = 1'b1;
		w.exe_mem_op_size = size;
		if (store) begin
			w.src_reg_used = SRC_USED_RS1_RS2;
			w.dec_src2_select = SRC2_REG;		// rs2 is the data
			w.exe_mem_op = MEM_STORE_OP;
		end else begin
			w.src_reg_used = SRC_USED_RS1;
			w.dec_src2_select = SRC2_IMM12;
			w.dec_not_sign_ext = zext;
			w.exe_alu_add_en = 1'b1;		// Effective address
			w.exe_reg_wr_en = 1'b1;
			w.exe_mem_op = MEM_LOAD_OP;
		end
		return w;
	endfunction

	// Operand fields common to every ALU operation
	function automatic dec_control_word_t alu_word(logic reg_form);
		dec_control_word_t w;
		w = '0;
		w.src_reg_used = reg_form ? SRC_USED_RS1_RS2 : SRC_USED_RS1;
		w.dec_src1_select = SRC1_REG;
		w.dec_src2_select = reg_form ? SRC2_REG : SRC2_IMM12;
		w.exe_reg_wr_en = 1'b1;
		return w;
	endfunction

	function automatic dec_control_word_t branch_word(logic [1:0] cond, logic neg, logic uns);
		dec_control_word_t w;
		w = '0;
		w.src_reg_used = SRC_USED_RS1_RS2;
		w.dec_src1_select = SRC1_REG;
		w.dec_src2_select = SRC2_REG;
		w.exe_bju_en = BJU_BRANCH;
		w.exe_condition_sel = cond;
		w.exe_condition_neg = neg;
		w.exe_alu_unsigned_n_en = uns;
		return w;
	endfunction

	task automatic add_entry(logic [4:0] major, logic [2:0] minor, logic alt, logic invalid,
		dec_control_word_t exp);
		stim_entry_t e;
		e.addr.major = urom_major_e'(major);
		e.addr.minor = minor;
		e.addr.alt = alt;
		e.invalid = invalid;
		e.exp = exp;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		dec_control_word_t w;
		logic [4:0]        maj;
		logic              form;
		add_entry(MAJOR_LOAD, MINOR_LB, 1'b0, 1'b0, mem_word(1'b0, MEM_SIZE_BYTE, 1'b0));
		add_entry(MAJOR_LOAD, MINOR_LH, 1'b0, 1'b0, mem_word(1'b0, MEM_SIZE_HALF, 1'b0));
		add_entry(MAJOR_LOAD, MINOR_LW, 1'b0, 1'b0, mem_word(1'b0, MEM_SIZE_WORD, 1'b0));
		add_entry(MAJOR_LOAD, MINOR_LBU, 1'b0, 1'b0, mem_word(1'b0, MEM_SIZE_BYTE, 1'b1));
		add_entry(MAJOR_LOAD, MINOR_LHU, 1'b0, 1'b0, mem_word(1'b0, MEM_SIZE_HALF, 1'b1));
		add_entry(MAJOR_STORE, MINOR_SB, 1'b0, 1'b0, mem_word(1'b1, MEM_SIZE_BYTE, 1'b0));
		add_entry(MAJOR_STORE, MINOR_SH, 1'b0, 1'b0, mem_word(1'b1, MEM_SIZE_HALF, 1'b0));
		add_entry(MAJOR_STORE, MINOR_SW, 1'b0, 1'b0, mem_word(1'b1, MEM_SIZE_WORD, 1'b0));
		for (int f = 0; f < 2; f++) begin		// Immediate form first
			form = (f == 1);
			maj = form ? MAJOR_REG : MAJOR_IMM;
			w = alu_word(form);
			w.exe_alu_add_en = 1'b1;
			add_entry(maj, MINOR_ADD, 1'b0, 1'b0, w);
			w = alu_word(form);
			w.exe_alu_sub_en = 1'b1;
			add_entry(maj, MINOR_ADD, 1'b1, 1'b0, form ? w : '0);		// No SUBI
			w = alu_word(form);
			w.exe_shu_shift_en = SHIFT_LL;
			add_entry(maj, MINOR_SLL, 1'b0, 1'b0, w);
			w = alu_word(form);
			w.exe_slt_en = 1'b1;
			w.exe_condition_sel = COND_NEG_BIT;
			add_entry(maj, MINOR_SLT, 1'b0, 1'b0, w);
			w.exe_alu_unsigned_n_en = 1'b1;
			w.dec_not_sign_ext = 1'b1;
			add_entry(maj, MINOR_SLTU, 1'b0, 1'b0, w);
			w = alu_word(form);
			w.exe_alu_logic_en = LOGIC_XOR;
			add_entry(maj, MINOR_XOR, 1'b0, 1'b0, w);
			w.exe_alu_logic_en = LOGIC_OR;
			add_entry(maj, MINOR_OR, 1'b0, 1'b0, w);
			w.exe_alu_logic_en = LOGIC_AND;
			add_entry(maj, MINOR_AND, 1'b0, 1'b0, w);
			w = alu_word(form);
			w.exe_shu_shift_en = SHIFT_RL;
			add_entry(maj, MINOR_SRL, 1'b0, 1'b0, w);
			w.exe_shu_shift_en = SHIFT_RA;
			add_entry(maj, MINOR_SRL, 1'b1, 1'b0, w);
			add_entry(maj, MINOR_SLL, 1'b1, 1'b0, '0);
		end
		w = '0;
		w.src_reg_used = SRC_USED_RS1;
		w.dec_src1_select = SRC1_UPPER;
		w.dec_src2_select = SRC2_UPPER;
		w.exe_reg_wr_en = 1'b1;
		add_entry(MAJOR_LUI, 3'b000, 1'b0, 1'b0, w);
		w.exe_add_pc_to_res_en = 1'b1;
		add_entry(MAJOR_AUIPC, 3'b000, 1'b0, 1'b0, w);
		add_entry(MAJOR_BRANCH, MINOR_BEQ, 1'b0, 1'b0, branch_word(COND_ZERO_BIT, 1'b0, 1'b0));
		add_entry(MAJOR_BRANCH, MINOR_BNE, 1'b0, 1'b0, branch_word(COND_ZERO_BIT, 1'b1, 1'b0));
		add_entry(MAJOR_BRANCH, MINOR_BLT, 1'b0, 1'b0, branch_word(COND_NEG_BIT, 1'b0, 1'b0));
		add_entry(MAJOR_BRANCH, MINOR_BGE, 1'b0, 1'b0, branch_word(COND_NEG_BIT, 1'b1, 1'b0));
		add_entry(MAJOR_BRANCH, MINOR_BLTU, 1'b0, 1'b0, branch_word(COND_NEG_BIT, 1'b0, 1'b1));
		add_entry(MAJOR_BRANCH, MINOR_BGEU, 1'b0, 1'b0, branch_word(COND_NEG_BIT, 1'b1, 1'b1));
		w = '0;
		w.src_reg_used = SRC_USED_RS1_RS2;
		w.dec_src2_select = SRC2_IMM12;
		w.exe_bju_en = BJU_JUMP_REG;
		w.exe_reg_wr_en = 1'b1;
		add_entry(MAJOR_JALR, 3'b000, 1'b0, 1'b0, w);
		w.src_reg_used = SRC_USED_NONE;
		w.dec_src2_select = SRC2_IMM20;
		w.exe_bju_en = BJU_JUMP;
		add_entry(MAJOR_JAL, 3'b000, 1'b0, 1'b0, w);
		// SYSTEM major and other unlisted slots
		add_entry(5'h1C, 3'b000, 1'b0, 1'b0, '0);
		add_entry(5'h1C, 3'b001, 1'b0, 1'b0, '0);
		add_entry(5'h1C, 3'b010, 1'b0, 1'b0, '0);
		add_entry(5'h03, 3'b000, 1'b0, 1'b0, '0);
		add_entry(MAJOR_LOAD, 3'b011, 1'b0, 1'b0, '0);
		add_entry(MAJOR_STORE, 3'b100, 1'b0, 1'b0, '0);
		add_entry(MAJOR_BRANCH, 3'b010, 1'b0, 1'b0, '0);
		add_entry(MAJOR_BRANCH, MINOR_BEQ, 1'b1, 1'b0, '0);
		add_entry(MAJOR_JAL, 3'b000, 1'b1, 1'b0, '0);
		// Valid addresses with the invalid flag raised
		add_entry(MAJOR_LOAD, MINOR_LW, 1'b0, 1'b1, '0);
		add_entry(MAJOR_REG, MINOR_ADD, 1'b1, 1'b1, '0);
		add_entry(MAJOR_BRANCH, MINOR_BGE, 1'b0, 1'b1, '0);
		add_entry(MAJOR_AUIPC, 3'b000, 1'b0, 1'b1, '0);
		add_entry(MAJOR_JAL, 3'b000, 1'b0, 1'b1, '0);
	endtask

	// Checks the word from the previous cycle, then presents the next address
	task automatic drive_entry(urom_addr_t addr, logic invalid, logic check_next,
		dec_control_word_t exp, string label);
		@(posedge clk);
		#DRIVE_DELAY;
		if (pend_valid) begin
			check_value(pend_label, pend_exp, urom_control_word_o);
		end
		urom_address_i = addr;
		urom_invalid_instr_i = invalid;
		pend_valid = check_next;
		pend_exp = exp;
		pend_label = label;
	endtask

	always @(posedge clk) begin : watchdog
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			errors++;
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			finish_run();
		end
	end

	initial begin : main
		logic [31:0] raw;
		urom_address_i = '0;
		urom_invalid_instr_i = 1'b0;		// Address zero is LB, only reset clears the word
		seed = 81;
		pend_valid = 1'b0;
		build_table();
		cycle_limit = table_q.size() + NUM_RANDOM + RESET_CYCLES + 20;
		wait (rst_n === 1'b1);
		check_value("urom_control_word_o after reset", '0, urom_control_word_o);
		foreach (table_q[i]) begin
			drive_entry(table_q[i].addr, table_q[i].invalid, 1'b1, table_q[i].exp,
				$sformatf("urom_control_word_o entry %0d", i));
		end
		for (int n = 0; n < NUM_RANDOM; n++) begin
			raw = $random(seed);
			drive_entry(urom_addr_t'(raw[8:0]), raw[9], raw[9], '0,
				$sformatf("urom_control_word_o random %0d", n));		// Invalid cycles only
		end
		drive_entry('0, 1'b1, 1'b0, '0, "idle");		// Flushes the last lookup
		finish_run();
	end

endmodule

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 5;		// 10 ns clock
	localparam int RESET_CYCLES = 4;

	initial begin : clock_gen
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin : reset_gen
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;		// Released off the edge
	end

endmodule
